// ==== logic/id_pkg.sv ====
// Decode stage shared definitions
`default_nettype none

package id_pkg;

  localparam int XLEN        = 64;
  localparam int INST_WD     = 32;
  localparam int REG_ADDR_WD = 5;
  localparam int REG_NUM     = 32;

  // rv64i major opcodes kept by this stage
  typedef enum logic [6:0] {
    OPC_LUI       = 7'b0110111,
    OPC_AUIPC     = 7'b0010111,
    OPC_JAL       = 7'b1101111,
    OPC_JALR      = 7'b1100111,
    OPC_BRANCH    = 7'b1100011,
    OPC_LOAD      = 7'b0000011,
    OPC_STORE     = 7'b0100011,
    OPC_OP_IMM    = 7'b0010011,
    OPC_OP        = 7'b0110011,
    OPC_OP_IMM_32 = 7'b0011011,
    OPC_OP_32     = 7'b0111011
  } opcode_e;

  typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B  // lui
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JUMP
  } br_func_e;

  // same encoding as funct3 of loads and stores
  typedef enum logic [2:0] {
    MEM_B  = 3'b000,
    MEM_H  = 3'b001,
    MEM_W  = 3'b010,
    MEM_D  = 3'b011,
    MEM_BU = 3'b100,
    MEM_HU = 3'b101,
    MEM_WU = 3'b110
  } mem_op_e;

  typedef enum logic {SRC1_RS1, SRC1_PC} src1_sel_e;

  typedef enum logic [1:0] {SRC2_RS2, SRC2_IMM, SRC2_FOUR} src2_sel_e;

endpackage

`default_nettype wire

// ==== logic/id_decoder.sv ====
// Instruction decoder
`timescale 1ns/1ps
`default_nettype none

module id_decoder
  import id_pkg::*;
(
  input  logic [INST_WD-1:0]     i_inst,
  output logic [REG_ADDR_WD-1:0] o_rs1,
  output logic [REG_ADDR_WD-1:0] o_rs2,
  output logic [REG_ADDR_WD-1:0] o_rd,
  output logic [XLEN-1:0]        o_imm,
  output alu_op_e                o_alu_op,
  output src1_sel_e              o_src1_sel,
  output src2_sel_e              o_src2_sel,
  output logic                   o_word_sel,
  output br_func_e               o_br_func,
  output logic                   o_gpr_wen,
  output logic                   o_mem_ren,
  output logic                   o_mem_wen,
  output mem_op_e                o_mem_op,
  output logic                   o_load_sel,
  output logic                   o_invalid_inst
);

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [6:0]      shift_f;
  logic            is_reg;
  logic            is_word;
  alu_op_e         arith_op;
  logic            arith_ok;
  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign o_rd   = i_inst[11:7];
  assign o_rs1  = i_inst[19:15];
  assign o_rs2  = i_inst[24:20];

  assign imm_i = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_u = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  assign is_reg  = (opcode == OPC_OP) || (opcode == OPC_OP_32);
  assign is_word = (opcode == OPC_OP_IMM_32) || (opcode == OPC_OP_32);
  // 64-bit shift immediates carry a 6-bit shamt, so only funct6 is fixed
  assign shift_f = (is_reg || is_word) ? funct7 : {i_inst[31:26], 1'b0};

  // op and legality for the OP / OP-IMM families
  always_comb begin
    arith_ok = 1'b1;
    case (funct3)
      3'b000:  arith_op = (is_reg && funct7[5]) ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = funct7[5] ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
    if (is_reg) begin
      arith_ok = (funct7 == 7'b0) ||
                 ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
    end
    if (funct3 == 3'b001 && shift_f != 7'b0) arith_ok = 1'b0;
    if (funct3 == 3'b101 && shift_f != 7'b0 && shift_f != 7'b0100000) arith_ok = 1'b0;
    if (is_word && funct3 != 3'b000 && funct3 != 3'b001 && funct3 != 3'b101) begin
      arith_ok = 1'b0;  // no slt/logic ops in the w forms
    end
  end

  always_comb begin
    o_imm          = imm_i;
    o_alu_op       = ALU_ADD;
    o_src1_sel     = SRC1_RS1;
    o_src2_sel     = SRC2_IMM;
    o_word_sel     = 1'b0;
    o_br_func      = BR_NONE;
    o_gpr_wen      = 1'b0;
    o_mem_ren      = 1'b0;
    o_mem_wen      = 1'b0;
    o_mem_op       = mem_op_e'(funct3);
    o_load_sel     = 1'b0;
    o_invalid_inst = 1'b0;
    case (opcode)
      OPC_LUI: begin
        o_imm     = imm_u;
        o_alu_op  = ALU_PASS_B;
        o_gpr_wen = 1'b1;
      end
      OPC_AUIPC: begin
        o_imm      = imm_u;
        o_src1_sel = SRC1_PC;
        o_gpr_wen  = 1'b1;
      end
      OPC_JAL, OPC_JALR: begin
        o_imm          = (opcode == OPC_JAL) ? imm_j : imm_i;
        o_src1_sel     = SRC1_PC;  // link = pc + 4
        o_src2_sel     = SRC2_FOUR;
        o_br_func      = BR_JUMP;
        o_gpr_wen      = 1'b1;
        o_invalid_inst = (opcode == OPC_JALR) && (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        o_imm = imm_b;
        case (funct3)
          3'b000:  o_br_func = BR_EQ;
          3'b001:  o_br_func = BR_NE;
          3'b100:  o_br_func = BR_LT;
          3'b101:  o_br_func = BR_GE;
          3'b110:  o_br_func = BR_LTU;
          3'b111:  o_br_func = BR_GEU;
          default: o_invalid_inst = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        o_mem_ren      = 1'b1;
        o_load_sel     = 1'b1;
        o_gpr_wen      = 1'b1;
        o_invalid_inst = (funct3 == 3'b111);
      end
      OPC_STORE: begin
        o_imm          = imm_s;
        o_mem_wen      = 1'b1;
        o_invalid_inst = funct3[2];  // sb/sh/sw/sd only
      end
      OPC_OP_IMM, OPC_OP_IMM_32, OPC_OP, OPC_OP_32: begin
        o_alu_op       = arith_op;
        o_src2_sel     = is_reg ? SRC2_RS2 : SRC2_IMM;
        o_word_sel     = is_word;
        o_gpr_wen      = 1'b1;
        o_invalid_inst = !arith_ok;
      end
      default: o_invalid_inst = 1'b1;
    endcase
    if (o_invalid_inst) begin
      o_gpr_wen  = 1'b0;
      o_mem_ren  = 1'b0;
      o_mem_wen  = 1'b0;
      o_load_sel = 1'b0;
      o_br_func  = BR_NONE;
    end
  end

endmodule

`default_nettype wire

// ==== logic/id_regfile.sv ====
// General register file
`timescale 1ns/1ps
`default_nettype none

module id_regfile
  import id_pkg::*;
(
  input  logic                   i_clk,
  input  logic [REG_ADDR_WD-1:0] i_raddr1,
  input  logic [REG_ADDR_WD-1:0] i_raddr2,
  input  logic                   i_wen,
  input  logic [REG_ADDR_WD-1:0] i_waddr,
  input  logic [XLEN-1:0]        i_wdata,
  output logic [XLEN-1:0]        o_rdata1,
  output logic [XLEN-1:0]        o_rdata2
);

  // x0 has no storage
  logic [XLEN-1:0] regs [1:REG_NUM-1];

  always_ff @(posedge i_clk) begin
    if (i_wen && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // wb bypass covers a read in the write cycle
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

`default_nettype wire

// ==== logic/id_operand_bypass.sv ====
// Operand bypass and load-use detect
`timescale 1ns/1ps
`default_nettype none

module id_operand_bypass
  import id_pkg::*;
(
  input  logic [REG_ADDR_WD-1:0] i_rs1,
  input  logic [REG_ADDR_WD-1:0] i_rs2,
  input  logic [XLEN-1:0]        i_rf_rdata1,
  input  logic [XLEN-1:0]        i_rf_rdata2,
  input  logic [REG_ADDR_WD-1:0] i_es_rd,
  input  logic [XLEN-1:0]        i_es_result,
  input  logic [REG_ADDR_WD-1:0] i_ms_rd,
  input  logic [XLEN-1:0]        i_ms_result,
  input  logic [REG_ADDR_WD-1:0] i_ws_rd,
  input  logic [XLEN-1:0]        i_ws_result,
  input  logic                   i_es_load_sel,
  output logic [XLEN-1:0]        o_rs1_data,
  output logic [XLEN-1:0]        o_rs2_data,
  output logic                   o_load_stall
);

  // youngest producer wins so es beats ms beats ws
  function automatic logic [XLEN-1:0] pick(
    input logic [REG_ADDR_WD-1:0] rs,
    input logic [XLEN-1:0]        rf_data,
    input logic [REG_ADDR_WD-1:0] es_rd,
    input logic [XLEN-1:0]        es_res,
    input logic [REG_ADDR_WD-1:0] ms_rd,
    input logic [XLEN-1:0]        ms_res,
    input logic [REG_ADDR_WD-1:0] ws_rd,
    input logic [XLEN-1:0]        ws_res
  );
    if (es_rd != '0 && rs == es_rd) return es_res;
    if (ms_rd != '0 && rs == ms_rd) return ms_res;
    if (ws_rd != '0 && rs == ws_rd) return ws_res;
    return rf_data;
  endfunction

  assign o_rs1_data = pick(i_rs1, i_rf_rdata1, i_es_rd, i_es_result,
                           i_ms_rd, i_ms_result, i_ws_rd, i_ws_result);
  assign o_rs2_data = pick(i_rs2, i_rf_rdata2, i_es_rd, i_es_result,
                           i_ms_rd, i_ms_result, i_ws_rd, i_ws_result);

  // load data only exists once the load reaches mem
  assign o_load_stall = i_es_load_sel && ((i_es_rd == i_rs1) || (i_es_rd == i_rs2));

endmodule

`default_nettype wire

// ==== logic/id_branch_unit.sv ====
// Branch and jump resolution
`timescale 1ns/1ps
`default_nettype none

module id_branch_unit
  import id_pkg::*;
(
  input  br_func_e        i_br_func,
  input  logic            i_is_jalr,
  input  logic [XLEN-1:0] i_rs1_data,
  input  logic [XLEN-1:0] i_rs2_data,
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_imm,
  output logic            o_br_taken,
  output logic [XLEN-1:0] o_br_target
);

  logic            eq;
  logic            lt_s;
  logic            lt_u;
  logic [XLEN-1:0] jalr_sum;

  assign eq   = (i_rs1_data == i_rs2_data);
  assign lt_s = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign lt_u = (i_rs1_data < i_rs2_data);

  always_comb begin
    case (i_br_func)
      BR_EQ:   o_br_taken = eq;
      BR_NE:   o_br_taken = !eq;
      BR_LT:   o_br_taken = lt_s;
      BR_GE:   o_br_taken = !lt_s;
      BR_LTU:  o_br_taken = lt_u;
      BR_GEU:  o_br_taken = !lt_u;
      BR_JUMP: o_br_taken = 1'b1;
      default: o_br_taken = 1'b0;
    endcase
  end

  assign jalr_sum = i_rs1_data + i_imm;

  // jalr drops bit 0
  assign o_br_target = i_is_jalr ? {jalr_sum[XLEN-1:1], 1'b0} : (i_pc + i_imm);

endmodule

`default_nettype wire

// ==== logic/id_stage.sv ====
// Instruction decode stage
`timescale 1ns/1ps
`default_nettype none

module id_stage
  import id_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  // fetch
  input  logic                   i_fs_to_ds_valid,
  input  logic [INST_WD-1:0]     i_fs_inst,
  input  logic [XLEN-1:0]        i_fs_pc,
  output logic                   o_ds_allowin,
  // execute
  input  logic                   i_es_allowin,
  output logic                   o_ds_to_es_valid,
  output logic [XLEN-1:0]        o_rs1_data,
  output logic [XLEN-1:0]        o_rs2_data,
  output logic [XLEN-1:0]        o_imm,
  output logic [XLEN-1:0]        o_pc,
  output alu_op_e                o_alu_op,
  output src1_sel_e              o_src1_sel,
  output src2_sel_e              o_src2_sel,
  output logic                   o_word_sel,
  output logic [REG_ADDR_WD-1:0] o_rd,
  output logic                   o_gpr_wen,
  output logic                   o_mem_ren,
  output logic                   o_mem_wen,
  output mem_op_e                o_mem_op,
  output logic                   o_load_sel,
  output logic                   o_invalid_inst,
  // write-back to rf
  input  logic                   i_ws_gpr_wen,
  input  logic [REG_ADDR_WD-1:0] i_ws_gpr_waddr,
  input  logic [XLEN-1:0]        i_ws_gpr_wdata,
  // bypass
  input  logic [REG_ADDR_WD-1:0] i_es_rd,
  input  logic [XLEN-1:0]        i_es_result,
  input  logic [REG_ADDR_WD-1:0] i_ms_rd,
  input  logic [XLEN-1:0]        i_ms_result,
  input  logic [REG_ADDR_WD-1:0] i_ws_rd,
  input  logic [XLEN-1:0]        i_ws_result,
  input  logic                   i_es_load_sel,
  // redirect to fetch
  output logic                   o_br_taken,
  output logic [XLEN-1:0]        o_br_target,
  output logic                   o_br_stall
);

  logic                   ds_valid;
  logic                   ready_go;
  logic                   load_stall;
  logic [INST_WD-1:0]     ds_inst;
  logic [XLEN-1:0]        ds_pc_r;
  logic [REG_ADDR_WD-1:0] rs1, rs2;
  logic [XLEN-1:0]        rf_rdata1, rf_rdata2;
  br_func_e               br_func;
  logic                   br_taken_raw;

  assign ready_go         = !load_stall;
  assign o_ds_allowin     = !ds_valid || (ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ready_go;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      ds_inst <= i_fs_inst;
      ds_pc_r <= i_fs_pc;
    end
  end

  assign o_pc = ds_pc_r;

  id_decoder u_decoder (
    .i_inst         (ds_inst),
    .o_rs1          (rs1),
    .o_rs2          (rs2),
    .o_rd           (o_rd),
    .o_imm          (o_imm),
    .o_alu_op       (o_alu_op),
    .o_src1_sel     (o_src1_sel),
    .o_src2_sel     (o_src2_sel),
    .o_word_sel     (o_word_sel),
    .o_br_func      (br_func),
    .o_gpr_wen      (o_gpr_wen),
    .o_mem_ren      (o_mem_ren),
    .o_mem_wen      (o_mem_wen),
    .o_mem_op       (o_mem_op),
    .o_load_sel     (o_load_sel),
    .o_invalid_inst (o_invalid_inst)
  );

  id_regfile u_regfile (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .i_wen    (i_ws_gpr_wen),
    .i_waddr  (i_ws_gpr_waddr),
    .i_wdata  (i_ws_gpr_wdata),
    .o_rdata1 (rf_rdata1),
    .o_rdata2 (rf_rdata2)
  );

  id_operand_bypass u_bypass (
    .i_rs1         (rs1),
    .i_rs2         (rs2),
    .i_rf_rdata1   (rf_rdata1),
    .i_rf_rdata2   (rf_rdata2),
    .i_es_rd       (i_es_rd),
    .i_es_result   (i_es_result),
    .i_ms_rd       (i_ms_rd),
    .i_ms_result   (i_ms_result),
    .i_ws_rd       (i_ws_rd),
    .i_ws_result   (i_ws_result),
    .i_es_load_sel (i_es_load_sel),
    .o_rs1_data    (o_rs1_data),
    .o_rs2_data    (o_rs2_data),
    .o_load_stall  (load_stall)
  );

  id_branch_unit u_branch (
    .i_br_func   (br_func),
    .i_is_jalr   (ds_inst[6:0] == OPC_JALR),
    .i_rs1_data  (o_rs1_data),
    .i_rs2_data  (o_rs2_data),
    .i_pc        (ds_pc_r),
    .i_imm       (o_imm),
    .o_br_taken  (br_taken_raw),
    .o_br_target (o_br_target)
  );

  assign o_br_taken = ds_valid && br_taken_raw;
  assign o_br_stall = o_br_taken && load_stall;  // operands still in flight

endmodule

`default_nettype wire

// ==== bench/id_stage_assertions.sv ====
// Decode pipeline control checks
`timescale 1ns/1ps
`default_nettype none

module id_stage_assertions
  import id_pkg::*;
(
  input logic                   i_clk,
  input logic                   i_arst_n,
  input logic                   i_es_allowin,
  input logic                   i_es_load_sel,
  input logic [REG_ADDR_WD-1:0] i_es_rd,
  input logic [INST_WD-1:0]     i_inst,
  input logic                   i_ds_allowin,
  input logic                   i_ds_to_es_valid,
  input logic                   i_br_taken,
  input logic                   i_br_stall
);

  a_blocked_allowin: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_ds_to_es_valid && !i_es_allowin) |-> !i_ds_allowin)
    else $error("decode accepts an instruction while execute is blocked");

  a_stall_taken: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_br_stall |-> i_br_taken)
    else $error("branch stall raised without a taken branch");

  a_load_use: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_es_load_sel && (i_es_rd == i_inst[19:15] || i_es_rd == i_inst[24:20]))
      |-> !i_ds_to_es_valid)
    else $error("decode passed an instruction on during a load-use hazard");

endmodule

bind id_stage id_stage_assertions u_assertions (
  .i_clk            (i_clk),
  .i_arst_n         (i_arst_n),
  .i_es_allowin     (i_es_allowin),
  .i_es_load_sel    (i_es_load_sel),
  .i_es_rd          (i_es_rd),
  .i_inst           (ds_inst),
  .i_ds_allowin     (o_ds_allowin),
  .i_ds_to_es_valid (o_ds_to_es_valid),
  .i_br_taken       (o_br_taken),
  .i_br_stall       (o_br_stall)
);

`default_nettype wire

// ==== bench/tb_id_stage.sv ====
// Decode stage testbench
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage
  import id_pkg::*;
();

  logic                   i_clk;
  logic                   i_arst_n;
  logic                   i_fs_to_ds_valid;
  logic [INST_WD-1:0]     i_fs_inst;
  logic [XLEN-1:0]        i_fs_pc;
  logic                   o_ds_allowin;
  logic                   i_es_allowin;
  logic                   o_ds_to_es_valid;
  logic [XLEN-1:0]        o_rs1_data, o_rs2_data, o_imm, o_pc;
  alu_op_e                o_alu_op;
  src1_sel_e              o_src1_sel;
  src2_sel_e              o_src2_sel;
  logic                   o_word_sel;
  logic [REG_ADDR_WD-1:0] o_rd;
  logic                   o_gpr_wen, o_mem_ren, o_mem_wen;
  mem_op_e                o_mem_op;
  logic                   o_load_sel, o_invalid_inst;
  logic                   i_ws_gpr_wen;
  logic [REG_ADDR_WD-1:0] i_ws_gpr_waddr;
  logic [XLEN-1:0]        i_ws_gpr_wdata;
  logic [REG_ADDR_WD-1:0] i_es_rd, i_ms_rd, i_ws_rd;
  logic [XLEN-1:0]        i_es_result, i_ms_result, i_ws_result;
  logic                   i_es_load_sel;
  logic                   o_br_taken;
  logic [XLEN-1:0]        o_br_target;
  logic                   o_br_stall;

  integer          seed;
  int              checks;
  int              errors;
  int              wait_limit = 32;
  logic [XLEN-1:0] rf3, rf7;  // values written to x3 and x7

  id_stage i_id_stage (.*);

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] btype(input logic [12:0] off, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  task automatic check_val(input string name, input logic [XLEN-1:0] got,
                           input logic [XLEN-1:0] exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("timed out waiting for %s", what);
  endtask

  // hold the instruction on the fetch side until decode takes it
  task automatic capture(input logic [INST_WD-1:0] inst, input logic [XLEN-1:0] pc);
    int n;
    n = 0;
    @(posedge i_clk);
    i_fs_to_ds_valid <= 1'b1;
    i_fs_inst        <= inst;
    i_fs_pc          <= pc;
    do begin
      @(negedge i_clk);
      n++;
    end while (!o_ds_allowin && n < wait_limit);
    if (!o_ds_allowin) report_timeout("decode to accept an instruction");
    @(posedge i_clk);
    i_fs_to_ds_valid <= 1'b0;
    @(negedge i_clk);
  endtask

  task automatic wait_ds_valid(input string what);
    int n;
    n = 0;
    while (!o_ds_to_es_valid && n < wait_limit) begin
      @(negedge i_clk);
      n++;
    end
    if (!o_ds_to_es_valid) report_timeout(what);
  endtask

  task automatic set_bypass(input logic [4:0] es_rd, input logic [4:0] ms_rd,
                            input logic [4:0] ws_rd, input logic load);
    @(posedge i_clk);
    i_es_rd       <= es_rd;
    i_ms_rd       <= ms_rd;
    i_ws_rd       <= ws_rd;
    i_es_load_sel <= load;
    @(negedge i_clk);
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [XLEN-1:0] data);
    @(posedge i_clk);
    i_ws_gpr_wen   <= 1'b1;
    i_ws_gpr_waddr <= addr;
    i_ws_gpr_wdata <= data;
    @(posedge i_clk);
    i_ws_gpr_wen   <= 1'b0;
  endtask

  task automatic reset_values;
    check_val("o_ds_to_es_valid", 64'(o_ds_to_es_valid), 64'd0);
    check_val("o_ds_allowin", 64'(o_ds_allowin), 64'd1);
    check_val("o_br_taken", 64'(o_br_taken), 64'd0);
    check_val("o_br_stall", 64'(o_br_stall), 64'd0);
  endtask

  task automatic regfile_readback;
    rf3 = {$random(seed), $random(seed)};
    rf7 = {$random(seed), $random(seed)};
    set_bypass(5'd0, 5'd0, 5'd0, 1'b0);
    write_reg(5'd3, rf3);
    write_reg(5'd7, rf7);
    write_reg(5'd0, {$random(seed), $random(seed)});
    capture(rtype(7'h00, 5'd7, 5'd3, 3'b000, 5'd1, OPC_OP), 64'h8000_0000);
    check_val("o_rs1_data", o_rs1_data, rf3);
    check_val("o_rs2_data", o_rs2_data, rf7);
    capture(rtype(7'h00, 5'd7, 5'd0, 3'b000, 5'd1, OPC_OP), 64'h8000_0004);
    check_val("o_rs1_data", o_rs1_data, 64'd0);
  endtask

  task automatic bypass_priority;
    logic [XLEN-1:0] es_v, ms_v, ws_v;
    es_v = {$random(seed), $random(seed)};
    ms_v = {$random(seed), $random(seed)};
    ws_v = {$random(seed), $random(seed)};
    capture(rtype(7'h00, 5'd7, 5'd3, 3'b000, 5'd1, OPC_OP), 64'h8000_0008);
    @(posedge i_clk);
    i_es_result <= es_v;
    i_ms_result <= ms_v;
    i_ws_result <= ws_v;
    set_bypass(5'd3, 5'd3, 5'd7, 1'b0);
    check_val("o_rs1_data", o_rs1_data, es_v);
    check_val("o_rs2_data", o_rs2_data, ws_v);
    set_bypass(5'd0, 5'd3, 5'd3, 1'b0);
    check_val("o_rs1_data", o_rs1_data, ms_v);
    check_val("o_rs2_data", o_rs2_data, rf7);
    set_bypass(5'd0, 5'd7, 5'd7, 1'b0);
    check_val("o_rs1_data", o_rs1_data, rf3);
    check_val("o_rs2_data", o_rs2_data, ms_v);
    set_bypass(5'd0, 5'd0, 5'd0, 1'b0);
    check_val("o_rs1_data", o_rs1_data, rf3);
    check_val("o_rs2_data", o_rs2_data, rf7);
    // x0 source must not pick up a stage reporting destination 0
    capture(rtype(7'h00, 5'd0, 5'd0, 3'b000, 5'd1, OPC_OP), 64'h8000_000c);
    check_val("o_rs1_data", o_rs1_data, 64'd0);
    check_val("o_rs2_data", o_rs2_data, 64'd0);
  endtask

  task automatic expect_decode(input logic [31:0] inst, input logic chk_imm,
                               input logic [XLEN-1:0] exp_imm, input alu_op_e exp_alu,
                               input src1_sel_e exp_src1, input src2_sel_e exp_src2,
                               input logic [4:0] exp_rd, input logic exp_word,
                               input logic exp_gpr, input logic exp_ren,
                               input logic exp_wen, input mem_op_e exp_op,
                               input logic exp_load, input logic exp_inv);
    capture(inst, 64'h1000);
    if (chk_imm) check_val("o_imm", o_imm, exp_imm);
    if (!exp_inv) begin
      check_val("o_alu_op", 64'(o_alu_op), 64'(exp_alu));
      check_val("o_src2_sel", 64'(o_src2_sel), 64'(exp_src2));
      // lui ignores the first operand
      if (exp_alu != ALU_PASS_B) check_val("o_src1_sel", 64'(o_src1_sel), 64'(exp_src1));
    end
    check_val("o_rd", 64'(o_rd), 64'(exp_rd));
    check_val("o_word_sel", 64'(o_word_sel), 64'(exp_word));
    check_val("o_gpr_wen", 64'(o_gpr_wen), 64'(exp_gpr));
    check_val("o_mem_ren", 64'(o_mem_ren), 64'(exp_ren));
    check_val("o_mem_wen", 64'(o_mem_wen), 64'(exp_wen));
    if (exp_ren || exp_wen) check_val("o_mem_op", 64'(o_mem_op), 64'(exp_op));
    check_val("o_load_sel", 64'(o_load_sel), 64'(exp_load));
    check_val("o_invalid_inst", 64'(o_invalid_inst), 64'(exp_inv));
  endtask

  task automatic decode_fields;
    expect_decode({20'hABCDE, 5'd5, OPC_LUI}, 1'b1, 64'hFFFF_FFFF_ABCD_E000, ALU_PASS_B,
                  SRC1_RS1, SRC2_IMM, 5'd5, 1'b0, 1'b1, 1'b0, 1'b0, MEM_B, 1'b0, 1'b0);
    expect_decode({20'h12345, 5'd6, OPC_AUIPC}, 1'b1, 64'h0000_0000_1234_5000, ALU_ADD,
                  SRC1_PC, SRC2_IMM, 5'd6, 1'b0, 1'b1, 1'b0, 1'b0, MEM_B, 1'b0, 1'b0);
    expect_decode(itype(12'hFFD, 5'd1, 3'b000, 5'd7, OPC_OP_IMM), 1'b1,
                  64'hFFFF_FFFF_FFFF_FFFD, ALU_ADD, SRC1_RS1, SRC2_IMM, 5'd7, 1'b0, 1'b1,
                  1'b0, 1'b0, MEM_B, 1'b0, 1'b0);
    expect_decode(rtype(7'h00, 5'd3, 5'd2, 3'b000, 5'd8, OPC_OP_32), 1'b0, 64'd0, ALU_ADD,
                  SRC1_RS1, SRC2_RS2, 5'd8, 1'b1, 1'b1, 1'b0, 1'b0, MEM_B, 1'b0, 1'b0);
    expect_decode(itype(12'hFF0, 5'd4, 3'b011, 5'd9, OPC_LOAD), 1'b1,
                  64'hFFFF_FFFF_FFFF_FFF0, ALU_ADD, SRC1_RS1, SRC2_IMM, 5'd9, 1'b0, 1'b1,
                  1'b1, 1'b0, MEM_D, 1'b1, 1'b0);
    // sd x5, 40(x6) keeps the low immediate bits in the rd field
    expect_decode(rtype(7'h01, 5'd5, 5'd6, 3'b011, 5'd8, OPC_STORE), 1'b1, 64'd40, ALU_ADD,
                  SRC1_RS1, SRC2_IMM, 5'd8, 1'b0, 1'b0, 1'b0, 1'b1, MEM_D, 1'b0, 1'b0);
    expect_decode({25'd0, 7'b1111111}, 1'b0, 64'd0, ALU_ADD, SRC1_RS1, SRC2_IMM, 5'd0,
                  1'b0, 1'b0, 1'b0, 1'b0, MEM_B, 1'b0, 1'b1);
  endtask

  task automatic stall_handling;
    @(posedge i_clk);
    i_es_allowin <= 1'b0;
    capture(itype(12'h001, 5'd1, 3'b000, 5'd2, OPC_OP_IMM), 64'h2000);
    @(posedge i_clk);
    i_fs_to_ds_valid <= 1'b1;
    i_fs_pc          <= 64'h3000;
    repeat (3) begin
      @(negedge i_clk);
      check_val("o_ds_allowin", 64'(o_ds_allowin), 64'd0);
      check_val("o_pc", o_pc, 64'h2000);
    end
    @(posedge i_clk);
    i_es_allowin     <= 1'b1;
    i_fs_to_ds_valid <= 1'b0;
    capture(itype(12'h001, 5'd1, 3'b000, 5'd2, OPC_OP_IMM), 64'h3000);
    check_val("o_pc", o_pc, 64'h3000);
    // load in execute writes rs1
    set_bypass(5'd5, 5'd0, 5'd0, 1'b1);
    capture(rtype(7'h00, 5'd6, 5'd5, 3'b000, 5'd9, OPC_OP), 64'h4000);
    check_val("o_ds_to_es_valid", 64'(o_ds_to_es_valid), 64'd0);
    check_val("o_ds_allowin", 64'(o_ds_allowin), 64'd0);
    set_bypass(5'd5, 5'd0, 5'd0, 1'b0);
    wait_ds_valid("the load-use stall to clear");
    check_val("o_pc", o_pc, 64'h4000);
    set_bypass(5'd0, 5'd0, 5'd0, 1'b0);
  endtask

  task automatic branch_resolution;
    logic [XLEN-1:0] a, b, pc, exp_tgt;
    logic [31:0]     rnd;
    logic [12:0]     off;
    logic [2:0]      f3;
    logic            exp_taken;
    int              r;
    int              k;
    set_bypass(5'd10, 5'd11, 5'd0, 1'b0);
    for (r = 0; r < 2; r++) begin
      for (k = 0; k < 5; k++) begin
        a   = {$random(seed), $random(seed)};
        b   = (r == 1) ? a : {$random(seed), $random(seed)};
        pc  = {$random(seed), $random(seed)};
        pc[1:0] = 2'b00;
        rnd = $random(seed);
        off = {rnd[12:1], 1'b0};
        case (k)
          0:       f3 = 3'b000;
          1:       f3 = 3'b001;
          2:       f3 = 3'b100;
          3:       f3 = 3'b110;
          default: f3 = 3'b101;
        endcase
        case (f3)
          3'b000:  exp_taken = (a == b);
          3'b001:  exp_taken = (a != b);
          3'b100:  exp_taken = ($signed(a) < $signed(b));
          3'b101:  exp_taken = ($signed(a) >= $signed(b));
          default: exp_taken = (a < b);
        endcase
        @(posedge i_clk);
        i_es_result <= a;
        i_ms_result <= b;
        capture(btype(off, 5'd11, 5'd10, f3), pc);
        check_val("o_br_taken", 64'(o_br_taken), 64'(exp_taken));
        check_val("o_br_target", o_br_target, pc + {{51{off[12]}}, off});
      end
    end
    capture({1'b0, 10'h000, 1'b0, 8'h01, 5'd1, OPC_JAL}, 64'h5000);  // jal x1, +4096
    check_val("o_br_taken", 64'(o_br_taken), 64'd1);
    check_val("o_br_target", o_br_target, 64'h6000);
    a    = {$random(seed), $random(seed)};
    a[0] = 1'b0;  // odd sum so bit 0 must be cleared
    @(posedge i_clk);
    i_es_result <= a;
    capture(itype(12'd5, 5'd10, 3'b000, 5'd1, OPC_JALR), 64'h7000);
    exp_tgt    = a + 64'd5;
    exp_tgt[0] = 1'b0;
    check_val("o_br_taken", 64'(o_br_taken), 64'd1);
    check_val("o_br_target", o_br_target, exp_tgt);
    // beq x10, x10 while the load producing x10 is in execute
    set_bypass(5'd10, 5'd0, 5'd0, 1'b1);
    capture(btype(13'h010, 5'd10, 5'd10, 3'b000), 64'h8000);
    check_val("o_br_taken", 64'(o_br_taken), 64'd1);
    check_val("o_br_stall", 64'(o_br_stall), 64'd1);
    set_bypass(5'd10, 5'd0, 5'd0, 1'b0);
    wait_ds_valid("the branch stall to clear");
    check_val("o_br_stall", 64'(o_br_stall), 64'd0);
    set_bypass(5'd0, 5'd0, 5'd0, 1'b0);
  endtask

  initial begin
    seed             = 32'he4dd_321c;
    checks           = 0;
    errors           = 0;
    i_arst_n         = 1'b0;
    i_fs_to_ds_valid = 1'b0;
    i_fs_inst        = '0;
    i_fs_pc          = '0;
    i_es_allowin     = 1'b1;
    i_ws_gpr_wen     = 1'b0;
    i_ws_gpr_waddr   = '0;
    i_ws_gpr_wdata   = '0;
    i_es_rd          = '0;
    i_ms_rd          = '0;
    i_ws_rd          = '0;
    i_es_result      = '0;
    i_ms_result      = '0;
    i_ws_result      = '0;
    i_es_load_sel    = 1'b0;
    repeat (16) @(posedge i_clk);
    i_arst_n <= 1'b1;
    @(negedge i_clk);
    reset_values();
    regfile_readback();
    bypass_priority();
    decode_fields();
    stall_handling();
    branch_resolution();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
logic/id_pkg.sv
logic/id_decoder.sv
logic/id_regfile.sv
logic/id_operand_bypass.sv
logic/id_branch_unit.sv
logic/id_stage.sv
bench/id_stage_assertions.sv
bench/tb_id_stage.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_id_stage -f build.f -o tb_id_stage

out=$(./obj_dir/tb_id_stage 2>&1 || true)
echo "$out"

if grep -qx "Test OK" <<< "$out"; then
  exit 0
fi
exit 1
